//--- rtl/conv2_coeff.sv
// weight and bias register store of the three filters, loaded through the coefficient write port
`timescale 1ns/100ps
`include "conv2_settings.svh"

module conv2_coeff (
   input  logic                                        clk,
   input  logic                                        rst_n,
   input  logic                                        coef_we,
   input  logic [`CONV2_COEF_AW-1:0]                   coef_addr,
   input  conv2_pkg::coef_t                            coef_data,
   output conv2_pkg::filter_w_t [`CONV2_CH_OUT-1:0]    weights,
   output conv2_pkg::coef_t     [`CONV2_CH_OUT-1:0]    biases
);
   import conv2_pkg::*;

   localparam int N_W = `CONV2_CH_OUT * `CONV2_CH_IN * `CONV2_WIN * `CONV2_WIN;  // 225
   localparam int N_B = `CONV2_CH_OUT;

   coef_t [N_W-1:0]          w_reg;     // flat, address f*75 + ch*25 + tap
   coef_t [N_B-1:0]          b_reg;
   logic [`CONV2_COEF_AW-1:0] bias_sel;  // address relative to the bias block

   assign bias_sel = coef_addr - `CONV2_COEF_AW'(N_W);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         w_reg <= '0;
         b_reg <= '0;
      end else if (coef_we) begin
         if (coef_addr < `CONV2_COEF_AW'(N_W)) begin
            w_reg[coef_addr] <= coef_data;
         end else if (bias_sel < `CONV2_COEF_AW'(N_B)) begin
            b_reg[bias_sel[1:0]] <= coef_data;
         end
         // anything above the bias block is dropped
      end
   end

   // flat order matches filter-major packing of the weight banks
   assign weights = w_reg;
   assign biases  = b_reg;

endmodule

//--- rtl/conv2_mac.sv
// one conv2 filter: 75-term multiply-accumulate, then shift, bias add and 12-bit wrap
`timescale 1ns/100ps
`include "conv2_settings.svh"

module conv2_mac (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 win_valid,
   input  conv2_pkg::window_t   win,
   input  conv2_pkg::filter_w_t weights,
   input  conv2_pkg::coef_t     bias,
   output logic                 out_valid,
   output conv2_pkg::pix_t      out_data
);
   import conv2_pkg::*;

   localparam int TAPS = `CONV2_WIN * `CONV2_WIN;

   acc_t sum;         // full precision product sum
   acc_t acc_q;
   logic acc_valid;
   acc_t scaled;
   acc_t biased;

   //////////////////////////////////////////////////////////////
   // stage one, product sum
   //////////////////////////////////////////////////////////////

   always_comb begin
      sum = '0;
      for (int ch = 0; ch < `CONV2_CH_IN; ch++) begin
         for (int t = 0; t < TAPS; t++) begin
            // both operands sign extended before the multiply
            sum = sum + acc_t'(pix_t'(win[t][ch])) * acc_t'(coef_t'(weights[ch*TAPS + t]));
         end
      end
   end

   always_ff @(posedge clk) begin
      if (win_valid) begin
         acc_q <= sum;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         acc_valid <= 1'b0;
      end else begin
         acc_valid <= win_valid;
      end
   end

   //////////////////////////////////////////////////////////////
   // stage two, scale and bias
   //////////////////////////////////////////////////////////////

   assign scaled = acc_q >>> `CONV2_SHIFT;   // arithmetic, keeps the sign
   assign biased = scaled + acc_t'(bias);

   always_ff @(posedge clk) begin
      if (acc_valid) begin
         out_data <= biased[`CONV2_PIX_W-1:0];   // wraps on overflow
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= acc_valid;
      end
   end

endmodule

//--- rtl/conv2_pkg.sv
// shared data types of the conv2 layer, imported by the window, coefficient, filter and top blocks
`include "conv2_settings.svh"

package conv2_pkg;

   //////////////////////////////////////////////////////////////
   // pixel data
   //////////////////////////////////////////////////////////////

   // one signed feature map value
   typedef logic signed [`CONV2_PIX_W-1:0] pix_t;

   // one map position across all input channels, index is the channel
   typedef pix_t [`CONV2_CH_IN-1:0] pix3_t;

   // full window, tap k is row k/5 and column k%5 from the top-left
   typedef pix3_t [`CONV2_WIN*`CONV2_WIN-1:0] window_t;

   //////////////////////////////////////////////////////////////
   // coefficients
   //////////////////////////////////////////////////////////////

   // signed weight or bias
   typedef logic signed [`CONV2_COEF_W-1:0] coef_t;

   // all weights of one filter, entry is channel*25 + tap
   typedef coef_t [`CONV2_CH_IN*`CONV2_WIN*`CONV2_WIN-1:0] filter_w_t;

   //////////////////////////////////////////////////////////////
   // arithmetic
   //////////////////////////////////////////////////////////////

   // product width plus growth for 75 terms, 27 bits
   typedef logic signed [`CONV2_PIX_W + `CONV2_COEF_W
                         + $clog2(`CONV2_CH_IN*`CONV2_WIN*`CONV2_WIN) - 1:0] acc_t;

endpackage

//--- rtl/conv2_settings.svh
// conv2 layer dimensions and widths, included by the package and every RTL file that needs them
`ifndef CONV2_SETTINGS_SVH
`define CONV2_SETTINGS_SVH

// feature map size
`define CONV2_IMG_W 12
`define CONV2_IMG_H 12

// filter window side, window is CONV2_WIN x CONV2_WIN
`define CONV2_WIN 5

// channel counts
`define CONV2_CH_IN  3
`define CONV2_CH_OUT 3

// data widths
`define CONV2_PIX_W  12   // signed pixel
`define CONV2_COEF_W 8    // signed weight and bias

// arithmetic right shift applied to the product sum
`define CONV2_SHIFT 7

// coefficient port address width
`define CONV2_COEF_AW 8

`endif

//--- rtl/conv2_top.sv
// conv2 layer top: window generator, coefficient store and three filters on plain ports
`timescale 1ns/100ps
`include "conv2_settings.svh"

module conv2_top (
   input  logic                                  clk,
   input  logic                                  rst_n,
   // pixel stream, raster order, no back-pressure
   input  logic                                  valid_in,
   input  conv2_pkg::pix3_t                      pixel_in,
   // coefficient write port
   input  logic                                  coef_we,
   input  logic [`CONV2_COEF_AW-1:0]             coef_addr,
   input  conv2_pkg::coef_t                      coef_data,
   // result stream, one value per filter
   output logic                                  out_valid,
   output conv2_pkg::pix_t [`CONV2_CH_OUT-1:0]   out_data
);
   import conv2_pkg::*;

   logic                           win_valid;
   window_t                        win;
   filter_w_t [`CONV2_CH_OUT-1:0]  weights;
   coef_t     [`CONV2_CH_OUT-1:0]  biases;

   conv2_window u_window (
      .clk       (clk),
      .rst_n     (rst_n),
      .valid_in  (valid_in),
      .pixel_in  (pixel_in),
      .win_valid (win_valid),
      .win       (win)
   );

   conv2_coeff u_coeff (
      .clk       (clk),
      .rst_n     (rst_n),
      .coef_we   (coef_we),
      .coef_addr (coef_addr),
      .coef_data (coef_data),
      .weights   (weights),
      .biases    (biases)
   );

   // all filters share timing, filter 0 supplies the valid
   conv2_mac u_mac0 (
      .clk       (clk),
      .rst_n     (rst_n),
      .win_valid (win_valid),
      .win       (win),
      .weights   (weights[0]),
      .bias      (biases[0]),
      .out_valid (out_valid),
      .out_data  (out_data[0])
   );

   conv2_mac u_mac1 (
      .clk       (clk),
      .rst_n     (rst_n),
      .win_valid (win_valid),
      .win       (win),
      .weights   (weights[1]),
      .bias      (biases[1]),
      .out_valid (),
      .out_data  (out_data[1])
   );

   conv2_mac u_mac2 (
      .clk       (clk),
      .rst_n     (rst_n),
      .win_valid (win_valid),
      .win       (win),
      .weights   (weights[2]),
      .bias      (biases[2]),
      .out_valid (),
      .out_data  (out_data[2])
   );

endmodule

//--- rtl/conv2_window.sv
// row buffering and 5x5 window forming for the three input channels, drives the conv2 filters
`timescale 1ns/100ps
`include "conv2_settings.svh"

module conv2_window (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               valid_in,
   input  conv2_pkg::pix3_t   pixel_in,
   output logic               win_valid,
   output conv2_pkg::window_t win
);
   import conv2_pkg::*;

   localparam int W  = `CONV2_IMG_W;
   localparam int H  = `CONV2_IMG_H;
   localparam int K  = `CONV2_WIN;
   localparam int CW = $clog2(W);
   localparam int RW = $clog2(H);

   // position of the pixel on valid_in
   logic [CW-1:0] col_cnt;
   logic [RW-1:0] row_cnt;
   logic          last_col;
   logic          full_pos;   // window ending here lies inside the map

   // registered input
   logic          valid_q;
   logic          full_q;
   pix3_t         pix_q;
   logic [CW-1:0] col_q;

   pix3_t line_mem [K-1][W];  // line k holds row r-1-k
   pix3_t new_col  [K];       // entering column, index 0 is the oldest row

   //////////////////////////////////////////////////////////////
   // raster position
   //////////////////////////////////////////////////////////////

   assign last_col = (col_cnt == CW'(W - 1));
   assign full_pos = (col_cnt >= CW'(K - 1)) && (row_cnt >= RW'(K - 1));

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         col_cnt <= '0;
         row_cnt <= '0;
      end else if (valid_in) begin
         if (last_col) begin
            col_cnt <= '0;
            // wrap after the last row so the next image follows directly
            row_cnt <= (row_cnt == RW'(H - 1)) ? '0 : row_cnt + 1'b1;
         end else begin
            col_cnt <= col_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_q <= 1'b0;
         full_q  <= 1'b0;
      end else begin
         valid_q <= valid_in;
         full_q  <= valid_in && full_pos;
      end
   end

   always_ff @(posedge clk) begin
      if (valid_in) begin
         pix_q <= pixel_in;
         col_q <= col_cnt;   // column of pix_q, addresses the line stores
      end
   end

   //////////////////////////////////////////////////////////////
   // line stores and window shift
   //////////////////////////////////////////////////////////////

   always_comb begin
      new_col[K-1] = pix_q;   // bottom row of the window
      for (int k = 0; k < K - 1; k++) begin
         new_col[K-2-k] = line_mem[k][col_q];
      end
   end

   // each line passes its old value at this column down to the next one
   always_ff @(posedge clk) begin
      if (valid_q) begin
         line_mem[0][col_q] <= pix_q;
         for (int k = 1; k < K - 1; k++) begin
            line_mem[k][col_q] <= line_mem[k-1][col_q];
         end
      end
   end

   // columns move left, newest column lands at the right edge
   always_ff @(posedge clk) begin
      if (valid_q) begin
         for (int r = 0; r < K; r++) begin
            for (int c = 0; c < K - 1; c++) begin
               win[r*K + c] <= win[r*K + c + 1];
            end
            win[r*K + K - 1] <= new_col[r];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         win_valid <= 1'b0;
      end else begin
         win_valid <= full_q;   // one pulse per complete window
      end
   end

endmodule

//--- run.sh
#!/usr/bin/env bash
# build and run the conv2 simulation with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module conv2_tb -o conv2_sim
./obj_dir/conv2_sim | tee sim.log

if grep -q "Regression failed" sim.log; then
   echo "simulation reported failure"
   exit 1
fi
echo "simulation clean"

//--- tests/conv2_assertions.sv
// concurrent checks on the conv2 top-level valid timing, bound into every conv2_top
`timescale 1ns/100ps

module conv2_assertions (
   input logic clk,
   input logic rst_n,
   input logic valid_in,
   input logic out_valid
);
   logic [5:0] accepted;   // pixels taken since reset, saturating

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         accepted <= '0;
      end else if (valid_in && accepted != 6'd63) begin
         accepted <= accepted + 1'b1;
      end
   end

   no_valid_in_reset: assert property (@(posedge clk) !rst_n |=> !out_valid)
      else $error("out_valid high after a reset cycle");

   // pixel accepted three edges before out_valid rose
   valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid |-> $past(valid_in, 4))
      else $error("out_valid without valid_in three cycles earlier");

   no_early_valid: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid |-> accepted >= 6'd25)
      else $error("out_valid before the 25th accepted pixel");

endmodule

bind conv2_top conv2_assertions u_assertions (
   .clk       (clk),
   .rst_n     (rst_n),
   .valid_in  (valid_in),
   .out_valid (out_valid)
);

//--- tests/conv2_golden.txt
# 228 coefficients (addr 0..224 weights f*75+ch*25+tap, 225..227 biases), 144 pixels {ch2,ch1,ch0}
# then 64 expected results {out2,out1,out0} in raster order, all hex
40 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 80 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 01 00 00 00
00 00 00 00 00 00 00 00 00 10 03 f0
0b00b00b0 0a00a00a0 090090090 080080080 070070070 060060060 050050050 040040040 030030030 020020020 010010010 000000000
1b01b01b0 1a01a01a0 190190190 180180180 170170170 160160160 150150150 140140140 130130130 120120120 110110110 100100100
2b02b02b0 2a02a02a0 290290290 280280280 270270270 260260260 250250250 240240240 230230230 220220220 210210210 200200200
3b03b03b0 3a03a03a0 390390390 380380380 370370370 360360360 350350350 340340340 330330330 320320320 310310310 300300300
4b04b04b0 4a04a04a0 490490490 480480480 470470470 460460460 450450450 440440440 430430430 420420420 410410410 400400400
5b05b05b0 5a05a05a0 590590590 580580580 570570570 560560560 550550550 540540540 530530530 520520520 510510510 500500500
6b06b06b0 6a06a06a0 690690690 680680680 670670670 660660660 650650650 640640640 630630630 620620620 610610610 600600600
7b07b07b0 7a07a07a0 790790790 780780780 770770770 760760760 750750750 740740740 730730730 720720720 710710710 700700700
8b08b08b0 8a08a08a0 890890890 880880880 870870870 860860860 850850850 840840840 830830830 820820820 810810810 800800800
9b09b09b0 9a09a09a0 990990990 980980980 970970970 960960960 950950950 940940940 930930930 920920920 910910910 900900900
ab0ab0ab0 aa0aa0aa0 a90a90a90 a80a80a80 a70a70a70 a60a60a60 a50a50a50 a40a40a40 a30a30a30 a20a20a20 a10a10a10 a00a00a00
bb0bb0bb0 ba0ba0ba0 b90b90b90 b80b80b80 b70b70b70 b60b60b60 b50b50b50 b40b40b40 b30b30b30 b20b20b20 b10b10b10 b00b00b00
ff5b93068 ff5ba3060 ff4bb3058 ff4bc3050 ff4bd3048 ff4be3040 ff4bf3038 ff4c03030
ff7a930e8 ff7aa30e0 ff6ab30d8 ff6ac30d0 ff6ad30c8 ff6ae30c0 ff6af30b8 ff6b030b0
ff9993168 ff99a3160 ff89b3158 ff89c3150 ff89d3148 ff89e3140 ff89f3138 ff8a03130
ffb8931e8 ffb8a31e0 ffa8b31d8 ffa8c31d0 ffa8d31c8 ffa8e31c0 ffa8f31b8 ffa9031b0
ffd793268 ffd7a3260 ffc7b3258 ffc7c3250 ffc7d3248 ffc7e3240 ffc7f3238 ffc803230
fff6932e8 fff6a32e0 ffe6b32d8 ffe6c32d0 ffe6d32c8 ffe6e32c0 ffe6f32b8 ffe7032b0
fe1593368 fe15a3360 fe05b3358 fe05c3350 fe05d3348 fe05e3340 fe05f3338 fe0603330
fe34933e8 fe34a33e0 fe24b33d8 fe24c33d0 fe24d33c8 fe24e33c0 fe24f33b8 fe25033b0

//--- tests/conv2_tb.sv
// conv2 testbench that loads the golden file, streams golden, gapped and back-to-back images and checks the results
`timescale 1ns/100ps

module conv2_tb;
   import conv2_pkg::*;

   localparam int N_PIX   = 144;
   localparam int N_OUT   = 64;
   localparam int N_COEF  = 228;
   localparam int N_TESTS = 5;
   localparam int TIMEOUT_CYC = N_TESTS * 200 + 1000;

   logic              clk = 1'b0;
   logic              rst_n;
   logic              valid_in;
   pix3_t             pixel_in;
   logic              coef_we;
   logic [7:0]        coef_addr;
   coef_t             coef_data;
   logic              out_valid;
   pix_t [2:0]        out_data;

   logic [35:0] img [N_PIX];        // image being streamed
   logic [7:0]  coef [N_COEF];      // copy of what the DUT store holds
   logic [7:0]  gold_coef [N_COEF];
   logic [35:0] gold_img [N_PIX];
   logic [35:0] gold_exp [N_OUT];
   logic [35:0] exp_q [$];
   int          lat_q [$];          // accepting edge of each full-window pixel
   logic [31:0] rng = 32'h71b9;
   int          errors = 0;
   int          cyc = 0;
   int          pos = 0;
   int          n_seen = 0;
   string       test_name = "init";

   always #4 clk = ~clk;
   always @(posedge clk) cyc <= cyc + 1;

   conv2_top u_conv2_top (
      .clk       (clk),
      .rst_n     (rst_n),
      .valid_in  (valid_in),
      .pixel_in  (pixel_in),
      .coef_we   (coef_we),
      .coef_addr (coef_addr),
      .coef_data (coef_data),
      .out_valid (out_valid),
      .out_data  (out_data)
   );

   ////////////////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////////////////

   function automatic logic [31:0] xorshift();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   task automatic check(input string name, input logic [35:0] expected, input logic [35:0] actual);
      if (actual !== expected) begin
         errors++;
         $display("FAILED %s expected %h actual %h", name, expected, actual);
      end
   endtask

   // sum of 75 products, shift by 7, add bias, keep 12 bits
   function automatic logic [11:0] ref_out(int f, int i, int j);
      longint            acc;
      logic signed [11:0] px;
      logic signed [7:0]  wt;
      acc = 0;
      for (int ch = 0; ch < 3; ch++) begin
         for (int t = 0; t < 25; t++) begin
            px  = img[(i + t / 5) * 12 + j + t % 5][ch*12 +: 12];
            wt  = coef[f*75 + ch*25 + t];
            acc = acc + longint'(px) * longint'(wt);
         end
      end
      acc = acc >>> 7;
      wt  = coef[225 + f];
      acc = acc + longint'(wt);
      return acc[11:0];
   endfunction

   task automatic idle_cycles(int n);
      repeat (n) begin
         @(posedge clk);
         #1;
         valid_in = 1'b0;
         coef_we  = 1'b0;
      end
   endtask

   task automatic write_coef(int addr, logic [7:0] data);
      @(posedge clk);
      #1;
      coef_we   = 1'b1;
      coef_addr = addr[7:0];
      coef_data = data;
      coef[addr] = data;
   endtask

   task automatic random_image();
      logic [63:0] r;
      for (int p = 0; p < N_PIX; p++) begin
         r = {xorshift(), xorshift()};
         img[p] = r[35:0];
      end
   endtask

   task automatic queue_model();
      logic [35:0] word;
      for (int k = 0; k < N_OUT; k++) begin
         for (int f = 0; f < 3; f++) word[f*12 +: 12] = ref_out(f, k / 8, k % 8);
         exp_q.push_back(word);
      end
   endtask

   task automatic send_image(bit gaps);
      logic [31:0] r;
      for (int p = 0; p < N_PIX; p++) begin
         r = xorshift();
         if (gaps && r[1:0] == 2'd0) idle_cycles(int'(r[3:2]) + 1);
         @(posedge clk);
         #1;
         valid_in = 1'b1;
         pixel_in = img[p];
      end
   endtask

   task automatic wait_results(int expected);
      int waited;
      waited = 0;
      while (exp_q.size() > 0 && waited < 20) begin
         @(posedge clk);
         waited++;
      end
      @(negedge clk);
      if (exp_q.size() > 0) begin
         errors++;
         $display("%0d results never came out in test %s", exp_q.size(), test_name);
         exp_q.delete();
      end
      check({test_name, " count"}, 36'(expected), 36'(n_seen));
   endtask

   task automatic load_golden();
      int fd;
      string line;
      fd = $fopen("tests/conv2_golden.txt", "r");
      if (fd == 0) begin
         errors++;
         $display("cannot open the golden file");
      end else begin
         void'($fgets(line, fd));   // two header lines
         void'($fgets(line, fd));
         for (int a = 0; a < N_COEF; a++) void'($fscanf(fd, "%h", gold_coef[a]));
         for (int p = 0; p < N_PIX; p++) void'($fscanf(fd, "%h", gold_img[p]));
         for (int k = 0; k < N_OUT; k++) begin
            if ($fscanf(fd, "%h", gold_exp[k]) != 1) begin
               errors++;
               $display("golden file ends early at result %0d", k);
               break;
            end
         end
         $fclose(fd);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // output monitor sampled mid-cycle
   ////////////////////////////////////////////////////////////

   always @(negedge clk) begin
      if (!rst_n) begin
         pos = 0;
      end else begin
         if (valid_in) begin
            if (pos / 12 >= 4 && pos % 12 >= 4) lat_q.push_back(cyc + 1);
            pos = (pos == N_PIX - 1) ? 0 : pos + 1;
         end
         if (out_valid) begin
            n_seen++;
            if (exp_q.size() == 0) begin
               errors++;
               $display("unexpected result %h in test %s", out_data, test_name);
            end else begin
               check(test_name, exp_q.pop_front(), out_data);
            end
            if (lat_q.size() == 0) begin
               errors++;
               $display("result without a full-window pixel in test %s", test_name);
            end else begin
               check({test_name, " latency"}, 36'(3), 36'(cyc - lat_q.pop_front()));
            end
         end
      end
   end

   initial begin
      repeat (TIMEOUT_CYC) @(posedge clk);
      $display("timeout, run still busy after %0d cycles", TIMEOUT_CYC);
      $display("Regression failed");
      $finish;
   end

   ////////////////////////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////////////////////////

   initial begin
      rst_n = 1'b0;
      valid_in = 1'b0;
      pixel_in = '0;
      coef_we = 1'b0;
      coef_addr = '0;
      coef_data = '0;
      foreach (coef[a]) coef[a] = 8'h00;   // store clears on reset
      load_golden();
      repeat (4) @(posedge clk);
      #1 rst_n = 1'b1;

      test_name = "reset";
      repeat (10) begin
         @(negedge clk);
         check(test_name, 36'(0), 36'(out_valid));
      end

      test_name = "golden";
      n_seen = 0;
      for (int a = 0; a < N_COEF; a++) write_coef(a, gold_coef[a]);
      idle_cycles(1);
      foreach (gold_img[p]) img[p] = gold_img[p];
      foreach (gold_exp[k]) exp_q.push_back(gold_exp[k]);
      send_image(1'b0);
      idle_cycles(1);
      wait_results(N_OUT);

      test_name = "gapped";
      n_seen = 0;
      for (int a = 0; a < N_COEF; a++) write_coef(a, 8'(xorshift()));
      idle_cycles(1);
      random_image();
      queue_model();
      send_image(1'b1);
      idle_cycles(1);
      wait_results(N_OUT);

      test_name = "back_to_back";
      n_seen = 0;
      random_image();
      queue_model();
      send_image(1'b0);
      random_image();
      queue_model();
      send_image(1'b0);   // no idle cycle between the two images
      idle_cycles(1);
      wait_results(2 * N_OUT);

      test_name = "reload";
      n_seen = 0;
      for (int a = 75; a < 150; a++) write_coef(a, 8'(xorshift()));   // filter 1 bank
      for (int a = 225; a < 228; a++) write_coef(a, 8'(xorshift()));
      idle_cycles(1);
      random_image();
      queue_model();
      send_image(1'b1);
      idle_cycles(1);
      wait_results(N_OUT);

      $display("errors: %0d, pending latency entries: %0d", errors, lat_q.size());
      if (errors == 0 && lat_q.size() == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

//--- verilog.f
+incdir+rtl
rtl/conv2_pkg.sv
rtl/conv2_window.sv
rtl/conv2_coeff.sv
rtl/conv2_mac.sv
rtl/conv2_top.sv
tests/conv2_assertions.sv
tests/conv2_tb.sv
